// ==== rtl/ttc_config.svh ====
/* widths and register map of the single-channel timer
   offsets are byte addresses on an 8-bit APB address, word aligned */
`ifndef TTC_CONFIG_SVH
`define TTC_CONFIG_SVH

// ------------------------------
// bus and counter widths
// ------------------------------
`define TTC_ADDR_W 8
`define TTC_CNT_W  16

// ------------------------------
// register offsets
// ------------------------------
// clock control, prescaler setup
`define TTC_OFS_CLK_CTRL 8'h00
// counter control, bit 4 is write-one restart
`define TTC_OFS_CNT_CTRL 8'h04
// live count, read only
`define TTC_OFS_COUNT    8'h08
`define TTC_OFS_INTERVAL 8'h0C
`define TTC_OFS_MATCH    8'h10
// status clears on read
`define TTC_OFS_INT_STAT 8'h14
`define TTC_OFS_INT_EN   8'h18

`endif

// ==== rtl/ttc_pkg.sv ====
/* types and bit positions shared by the timer RTL
   vector widths follow the config header */
`include "ttc_config.svh"

package ttc_pkg;

  // ------------------------------
  // vector types
  // ------------------------------
  typedef logic [`TTC_ADDR_W-1:0] apb_addr_t;
  typedef logic [31:0]            apb_data_t;
  typedef logic [6:0]             clk_ctrl_t;
  typedef logic [6:0]             cnt_ctrl_t;
  typedef logic [`TTC_CNT_W-1:0]  count_t;
  typedef logic [1:0]             int_vec_t;

  // clock control fields, N sits in bits 4:1
  localparam int CLK_PS_EN  = 0;
  localparam int CLK_PS_LSB = 1;

  // counter control fields
  localparam int CNT_DISABLE  = 0;
  localparam int CNT_INTERVAL = 1;
  localparam int CNT_DECR     = 2;
  localparam int CNT_MATCH_EN = 3;
  localparam int CNT_RESTART  = 4;

  // interrupt vector positions
  localparam int INT_OVF   = 0;
  localparam int INT_MATCH = 1;

endpackage

// ==== rtl/ttc_cnt_if.sv ====
/* control from the register file to the counter, events back
   count_en is driven at the top level from the restart block */
`timescale 1ns/1ps

interface ttc_cnt_if import ttc_pkg::*; ();

  // counter enable, low for one cycle on restart
  logic   count_en;

  // control bits out of cnt_ctrl
  logic   cnt_disable;
  logic   interval_mode;
  logic   decrement;
  logic   match_en;
  count_t interval_val;
  count_t match_val;

  // counter state and one-cycle events
  count_t count_val;
  logic   ovf_evt;
  logic   match_evt;

  modport regs (
    output cnt_disable, interval_mode, decrement, match_en,
    output interval_val, match_val,
    input  count_val, ovf_evt, match_evt
  );

  modport counter (
    input  count_en, cnt_disable, interval_mode, decrement, match_en,
    input  interval_val, match_val,
    output count_val, ovf_evt, match_evt
  );

endinterface

// ==== rtl/ttc_count_rst_lite.sv ====
/* clock control register and restart handling
   count_en drops for one cycle on each rising edge of restart
   clk_ctrl bits 6:5 are stored only, no external clock here */
`timescale 1ns/1ps

module ttc_count_rst_lite
  import ttc_pkg::*;
(
  input  logic      pclk30,
  input  logic      n_p_reset30,
  input  clk_ctrl_t pwdata,
  input  logic      clk_ctrl_sel,
  input  logic      restart,
  output logic      count_en,
  output clk_ctrl_t clk_ctrl
);

  // set while restart stays high after its first cycle
  logic restart_seen;

  // ------------------------------
  // count enable
  // ------------------------------
  // low straight after reset, high one cycle later
  always_ff @(posedge pclk30 or negedge n_p_reset30)
  begin : p_count_en
    if (!n_p_reset30)
    begin
      restart_seen <= 1'b0;
      count_en     <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      // rising edge of restart, one-cycle drop
      restart_seen <= 1'b1;
      count_en     <= 1'b0;
    end
    else
    begin
      // a long restart does not hold the enable low
      restart_seen <= restart;
      count_en     <= 1'b1;
    end
  end

  // ------------------------------
  // clock control register
  // ------------------------------
  always_ff @(posedge pclk30 or negedge n_p_reset30)
  begin : p_clk_ctrl
    if (!n_p_reset30)
    begin
      clk_ctrl <= '0;
    end
    else if (clk_ctrl_sel)
    begin
      clk_ctrl <= pwdata;
    end
  end

endmodule

// ==== rtl/ttc_regs.sv ====
/* APB register file, zero wait states, no pslverr
   INT_STAT clears on the read access edge; new events still set it
   clock control lives in the restart block and is only read here */
`timescale 1ns/1ps
`include "ttc_config.svh"

module ttc_regs
  import ttc_pkg::*;
(
  input  logic      pclk30,
  input  logic      n_p_reset30,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  input  clk_ctrl_t clk_ctrl,
  output logic      clk_ctrl_sel,
  output logic      restart,
  output logic      irq,
  ttc_cnt_if.regs   cnt
);

  // restart bit is never stored
  localparam cnt_ctrl_t CNT_WR_MASK = ~(cnt_ctrl_t'(1) << CNT_RESTART);

  logic      wr_en;
  logic      rd_en;
  logic      stat_rd;
  cnt_ctrl_t cnt_ctrl;
  count_t    interval_val;
  count_t    match_val;
  int_vec_t  int_en;
  int_vec_t  int_stat;
  int_vec_t  evt_vec;

  // ------------------------------
  // access decode
  // ------------------------------
  // access phase strobes
  assign wr_en = psel && penable && pwrite;
  assign rd_en = psel && penable && !pwrite;

  // clock control is loaded in the restart block
  assign clk_ctrl_sel = wr_en && (paddr == `TTC_OFS_CLK_CTRL);
  assign stat_rd      = rd_en && (paddr == `TTC_OFS_INT_STAT);

  // ------------------------------
  // control registers
  // ------------------------------
  always_ff @(posedge pclk30 or negedge n_p_reset30)
  begin : p_ctrl_regs
    if (!n_p_reset30)
    begin
      cnt_ctrl     <= '0;
      interval_val <= '0;
      match_val    <= '0;
      int_en       <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        `TTC_OFS_CNT_CTRL: cnt_ctrl     <= pwdata[$bits(cnt_ctrl_t)-1:0] & CNT_WR_MASK;
        `TTC_OFS_INTERVAL: interval_val <= pwdata[`TTC_CNT_W-1:0];
        `TTC_OFS_MATCH:    match_val    <= pwdata[`TTC_CNT_W-1:0];
        `TTC_OFS_INT_EN:   int_en       <= pwdata[$bits(int_vec_t)-1:0];
        default:           ;
      endcase
    end
  end

  // one-cycle pulse after the access edge
  always_ff @(posedge pclk30 or negedge n_p_reset30)
  begin : p_restart
    if (!n_p_reset30)
    begin
      restart <= 1'b0;
    end
    else
    begin
      restart <= wr_en && (paddr == `TTC_OFS_CNT_CTRL) && pwdata[CNT_RESTART];
    end
  end

  // ------------------------------
  // interrupt status
  // ------------------------------
  assign evt_vec[INT_OVF]   = cnt.ovf_evt;
  assign evt_vec[INT_MATCH] = cnt.match_evt;

  // sticky bits, set wins over the read clear
  always_ff @(posedge pclk30 or negedge n_p_reset30)
  begin : p_int_stat
    if (!n_p_reset30)
    begin
      int_stat <= '0;
    end
    else
    begin
      int_stat <= (stat_rd ? int_vec_t'(0) : int_stat) | evt_vec;
    end
  end

  // level interrupt
  assign irq = |(int_stat & int_en);

  // ------------------------------
  // counter control fan-out
  // ------------------------------
  assign cnt.cnt_disable   = cnt_ctrl[CNT_DISABLE];
  assign cnt.interval_mode = cnt_ctrl[CNT_INTERVAL];
  assign cnt.decrement     = cnt_ctrl[CNT_DECR];
  assign cnt.match_en      = cnt_ctrl[CNT_MATCH_EN];
  assign cnt.interval_val  = interval_val;
  assign cnt.match_val     = match_val;

  // ------------------------------
  // read mux
  // ------------------------------
  // combinational, valid through setup and access phase
  always_comb
  begin : p_rdata
    prdata = '0;
    if (psel && !pwrite)
    begin
      case (paddr)
        `TTC_OFS_CLK_CTRL: prdata = apb_data_t'(clk_ctrl);
        `TTC_OFS_CNT_CTRL: prdata = apb_data_t'(cnt_ctrl);
        // live value from the counter
        `TTC_OFS_COUNT:    prdata = apb_data_t'(cnt.count_val);
        `TTC_OFS_INTERVAL: prdata = apb_data_t'(interval_val);
        `TTC_OFS_MATCH:    prdata = apb_data_t'(match_val);
        `TTC_OFS_INT_STAT: prdata = apb_data_t'(int_stat);
        `TTC_OFS_INT_EN:   prdata = apb_data_t'(int_en);
        default:           prdata = '0;
      endcase
    end
  end

endmodule

// ==== rtl/ttc_prescaler.sv ====
/* power-of-two prescaler, tick every 2^(N+1) cycles when enabled
   divider is held at zero while count_en is low */
`timescale 1ns/1ps

module ttc_prescaler
  import ttc_pkg::*;
(
  input  logic      pclk30,
  input  logic      n_p_reset30,
  input  clk_ctrl_t clk_ctrl,
  input  logic      count_en,
  output logic      tick
);

  logic [15:0] div;
  logic [3:0]  ps_n;
  // low N+1 bits set
  logic [15:0] ps_mask;

  assign ps_n    = clk_ctrl[CLK_PS_LSB +: 4];
  assign ps_mask = ~(16'hfffe << ps_n);

  // ------------------------------
  // free-running divider
  // ------------------------------
  always_ff @(posedge pclk30 or negedge n_p_reset30)
  begin : p_div
    if (!n_p_reset30)
    begin
      div <= '0;
    end
    else if (!count_en)
    begin
      // restart clears the phase
      div <= '0;
    end
    else
    begin
      div <= div + 16'd1;
    end
  end

  // all masked bits ones, last cycle of the period
  // undivided when prescale is off
  assign tick = clk_ctrl[CLK_PS_EN] ? &(div | ~ps_mask) : 1'b1;

endmodule

// ==== rtl/ttc_counter.sv ====
/* up/down counter with interval reload and match compare
   up: wraps at max or at the interval; down: reloads at zero
   ovf_evt and match_evt are one-cycle pulses */
`timescale 1ns/1ps
`include "ttc_config.svh"

module ttc_counter
  import ttc_pkg::*;
(
  input  logic       pclk30,
  input  logic       n_p_reset30,
  input  logic       tick,
  ttc_cnt_if.counter cnt
);

  localparam count_t CNT_MAX = {`TTC_CNT_W{1'b1}};

  count_t count;
  count_t next_count;
  count_t reload_val;
  logic   at_limit;
  logic   step;
  logic   ovf_evt;
  logic   match_evt;

  assign step = cnt.count_en && !cnt.cnt_disable && tick;

  // ------------------------------
  // next count and wrap
  // ------------------------------
  always_comb
  begin : p_next
    if (cnt.decrement)
    begin
      // down, reload on zero
      at_limit   = (count == '0);
      reload_val = cnt.interval_mode ? cnt.interval_val : CNT_MAX;
      next_count = at_limit ? reload_val : count - count_t'(1);
    end
    else
    begin
      // up, >= so a lowered interval still wraps
      at_limit   = cnt.interval_mode ? (count >= cnt.interval_val) : (count == CNT_MAX);
      reload_val = '0;
      next_count = at_limit ? reload_val : count + count_t'(1);
    end
  end

  // ------------------------------
  // count register and events
  // ------------------------------
  always_ff @(posedge pclk30 or negedge n_p_reset30)
  begin : p_count
    if (!n_p_reset30)
    begin
      count     <= '0;
      ovf_evt   <= 1'b0;
      match_evt <= 1'b0;
    end
    else
    begin
      ovf_evt   <= 1'b0;
      match_evt <= 1'b0;
      if (!cnt.count_en)
      begin
        // restart, start point depends on direction
        count <= cnt.decrement ? cnt.interval_val : count_t'(0);
      end
      else if (step)
      begin
        count     <= next_count;
        ovf_evt   <= at_limit;
        // compare against the new value
        match_evt <= cnt.match_en && (next_count == cnt.match_val);
      end
    end
  end

  assign cnt.count_val = count;
  assign cnt.ovf_evt   = ovf_evt;
  assign cnt.match_evt = match_evt;

endmodule

// ==== rtl/ttc_timer_lite.sv ====
/* single-channel lite timer, APB slave with no wait states
   no pready or pslverr; irq is a level output */
`timescale 1ns/1ps
`include "ttc_config.svh"

module ttc_timer_lite
  import ttc_pkg::*;
(
  input  logic                  pclk30,
  input  logic                  n_p_reset30,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [`TTC_ADDR_W-1:0] paddr,
  input  apb_data_t             pwdata,
  output apb_data_t             prdata,
  output logic                  irq
);

  clk_ctrl_t clk_ctrl;
  logic      clk_ctrl_sel;
  logic      restart;
  logic      count_en;
  logic      tick;

  ttc_cnt_if cnt_if ();

  // restart block output into the interface
  assign cnt_if.count_en = count_en;

  // ------------------------------
  // register file
  // ------------------------------
  ttc_regs u_regs (
    .pclk30       (pclk30),
    .n_p_reset30  (n_p_reset30),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .clk_ctrl     (clk_ctrl),
    .clk_ctrl_sel (clk_ctrl_sel),
    .restart      (restart),
    .irq          (irq),
    .cnt          (cnt_if.regs)
  );

  // clock control and count enable
  ttc_count_rst_lite u_count_rst (
    .pclk30       (pclk30),
    .n_p_reset30  (n_p_reset30),
    .pwdata       (pwdata[$bits(clk_ctrl_t)-1:0]),
    .clk_ctrl_sel (clk_ctrl_sel),
    .restart      (restart),
    .count_en     (count_en),
    .clk_ctrl     (clk_ctrl)
  );

  // ------------------------------
  // count path
  // ------------------------------
  ttc_prescaler u_prescaler (
    .pclk30      (pclk30),
    .n_p_reset30 (n_p_reset30),
    .clk_ctrl    (clk_ctrl),
    .count_en    (count_en),
    .tick        (tick)
  );

  ttc_counter u_counter (
    .pclk30      (pclk30),
    .n_p_reset30 (n_p_reset30),
    .tick        (tick),
    .cnt         (cnt_if.counter)
  );

endmodule

// ==== test/ttc_props.sv ====
/* assertions on the timer top level, attached by bind
   reads the internal restart and count_en nets of ttc_timer_lite */
`timescale 1ns/1ps

module ttc_props (
  input logic        pclk30,
  input logic        n_p_reset30,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [31:0] prdata,
  input logic        irq,
  input logic        restart,
  input logic        count_en
);

  // ------------------------------
  // reset and enable
  // ------------------------------
  // no interrupt in reset or on the first edge out of it
  a_irq_reset: assert property (@(posedge pclk30)
    (!n_p_reset30 || $rose(n_p_reset30)) |-> !irq)
    else $error("irq high out of reset");

  // enable drop lasts a single cycle
  a_en_one_cycle: assert property (@(posedge pclk30) disable iff (!n_p_reset30)
    !count_en |=> count_en)
    else $error("count_en low for two cycles");

  // restart pulse clears the count path next cycle
  a_restart_drop: assert property (@(posedge pclk30) disable iff (!n_p_reset30)
    $rose(restart) |=> !count_en)
    else $error("count_en did not drop after restart");

  // ------------------------------
  // bus
  // ------------------------------
  a_rdata_known: assert property (@(posedge pclk30) disable iff (!n_p_reset30)
    (psel && penable && !pwrite) |-> !$isunknown(prdata))
    else $error("prdata unknown in read access");

endmodule

bind ttc_timer_lite ttc_props u_ttc_props (
  .pclk30      (pclk30),
  .n_p_reset30 (n_p_reset30),
  .psel        (psel),
  .penable     (penable),
  .pwrite      (pwrite),
  .prdata      (prdata),
  .irq         (irq),
  .restart     (restart),
  .count_en    (count_en)
);

// ==== test/tb_ttc_timer_lite.sv ====
/* directed testbench for the lite timer that stops at the first mismatch
   APB driven on falling edges and read data sampled in the low phase */
`timescale 1ns/1ps
`include "ttc_config.svh"

module tb_ttc_timer_lite;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  // idle cycles between enable and disable in the prescaler test
  localparam int PS_WAIT      = 200;
  // extra counting edges from the two APB writes around the wait
  localparam int APB_GAP      = 3;
  // largest random interval or match value
  localparam int MAX_LEN      = 47;
  localparam int TEST_CYCLES  = 150 + 3 * (PS_WAIT + 40) + 3 * (MAX_LEN + 80);
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * TEST_CYCLES) * CLK_PERIOD;

  logic                   pclk30;
  logic                   n_p_reset30;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`TTC_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   irq;
  logic [31:0]            rng_state;

  ttc_timer_lite u_ttc_timer_lite (
    .pclk30      (pclk30),
    .n_p_reset30 (n_p_reset30),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq)
  );

  always #(CLK_PERIOD / 2) pclk30 = ~pclk30;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  // setup and access phase then one idle cycle
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge pclk30);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge pclk30);
    penable = 1'b1;
    @(negedge pclk30);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // data taken a quarter period before the access edge
  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge pclk30);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge pclk30);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    data = prdata;
    @(negedge pclk30);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // polls irq once per falling edge
  task automatic wait_irq(input logic level, input int max_cycles, input string what);
    int n;
    n = 0;
    while (irq !== level && n < max_cycles)
    begin
      @(negedge pclk30);
      n++;
    end
    if (irq !== level)
    begin
      $display("irq did not reach %0d within %0d cycles in %s", level, max_cycles, what);
      abort_run();
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  // reset values then masked readback of the writable registers
  task automatic reset_and_readback();
    logic [31:0] val;
    logic [31:0] r;
    apb_read(`TTC_OFS_CLK_CTRL, val);
    check_equal("CLK_CTRL", val, 0);
    apb_read(`TTC_OFS_CNT_CTRL, val);
    check_equal("CNT_CTRL", val, 0);
    apb_read(`TTC_OFS_INTERVAL, val);
    check_equal("INTERVAL", val, 0);
    apb_read(`TTC_OFS_MATCH, val);
    check_equal("MATCH", val, 0);
    apb_read(`TTC_OFS_INT_STAT, val);
    check_equal("INT_STAT", val, 0);
    apb_read(`TTC_OFS_INT_EN, val);
    check_equal("INT_EN", val, 0);
    draw_random(r);
    apb_write(`TTC_OFS_CLK_CTRL, r);
    apb_read(`TTC_OFS_CLK_CTRL, val);
    check_equal("CLK_CTRL", val, r & 32'h7f);
    draw_random(r);
    apb_write(`TTC_OFS_INTERVAL, r);
    apb_read(`TTC_OFS_INTERVAL, val);
    check_equal("INTERVAL", val, r & 32'hffff);
    draw_random(r);
    apb_write(`TTC_OFS_MATCH, r);
    apb_read(`TTC_OFS_MATCH, val);
    check_equal("MATCH", val, r & 32'hffff);
    draw_random(r);
    apb_write(`TTC_OFS_INT_EN, r);
    apb_read(`TTC_OFS_INT_EN, val);
    check_equal("INT_EN", val, r & 32'h3);
    // restart bit reads back as zero
    draw_random(r);
    apb_write(`TTC_OFS_CNT_CTRL, r);
    apb_read(`TTC_OFS_CNT_CTRL, val);
    check_equal("CNT_CTRL", val, r & 32'h6f);
    // back to a quiet state
    apb_write(`TTC_OFS_CNT_CTRL, 32'h01);
    apb_write(`TTC_OFS_INT_EN, 32'h0);
    apb_write(`TTC_OFS_CLK_CTRL, 32'h0);
    apb_read(`TTC_OFS_INT_STAT, val);
  endtask

  // restart while disabled loads 0 going up and INTERVAL going down
  task automatic restart_while_disabled();
    logic [31:0] val;
    logic [31:0] r;
    logic [15:0] intv;
    draw_random(r);
    intv = r[15:0] | 16'h1;
    apb_write(`TTC_OFS_INTERVAL, 32'(intv));
    apb_write(`TTC_OFS_CNT_CTRL, 32'h11);
    apb_read(`TTC_OFS_COUNT, val);
    check_equal("COUNT", val, 0);
    repeat (5) @(negedge pclk30);
    apb_read(`TTC_OFS_COUNT, val);
    check_equal("COUNT", val, 0);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h15);
    apb_read(`TTC_OFS_COUNT, val);
    check_equal("COUNT", val, 32'(intv));
    repeat (5) @(negedge pclk30);
    apb_read(`TTC_OFS_COUNT, val);
    check_equal("COUNT", val, 32'(intv));
  endtask

  // count over a fixed window with two ticks of slack for the divider phase
  task automatic measure_count_rate(input logic ps_en, input int n);
    logic [31:0] val;
    int          expected;
    int          diff;
    apb_write(`TTC_OFS_CLK_CTRL, 32'((n << 1) | ps_en));
    apb_write(`TTC_OFS_CNT_CTRL, 32'h11);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h00);
    repeat (PS_WAIT) @(negedge pclk30);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h01);
    apb_read(`TTC_OFS_COUNT, val);
    expected = ps_en ? ((PS_WAIT + APB_GAP) >> (n + 1)) : (PS_WAIT + APB_GAP);
    diff     = int'(val) - expected;
    if (diff > 2 || diff < -2)
      check_equal("COUNT", val, 32'(expected));
  endtask

  task automatic prescaler_rates();
    logic [31:0] r;
    draw_random(r);
    measure_count_rate(1'b1, int'(r[1:0]));
    measure_count_rate(1'b0, 0);
    apb_write(`TTC_OFS_CLK_CTRL, 32'h0);
  endtask

  // overflow at the interval then clear on read
  task automatic interval_overflow();
    logic [31:0] val;
    logic [31:0] r;
    int          intv;
    draw_random(r);
    intv = 16 + int'(r[4:0]);
    apb_write(`TTC_OFS_INTERVAL, 32'(intv));
    apb_write(`TTC_OFS_INT_EN, 32'h1);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h13);
    apb_read(`TTC_OFS_INT_STAT, val);
    check_equal("irq", irq, 0);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h12);
    wait_irq(1'b1, intv + 4, "interval mode");
    apb_write(`TTC_OFS_CNT_CTRL, 32'h03);
    apb_read(`TTC_OFS_INT_STAT, val);
    check_equal("INT_STAT", val, 32'h1);
    apb_read(`TTC_OFS_INT_STAT, val);
    check_equal("INT_STAT", val, 32'h0);
    check_equal("irq", irq, 0);
    apb_write(`TTC_OFS_INT_EN, 32'h0);
  endtask

  // match with and without the interrupt enabled
  task automatic match_interrupt();
    logic [31:0] val;
    logic [31:0] r;
    int          m;
    draw_random(r);
    m = 5 + int'(r[3:0]);
    apb_write(`TTC_OFS_MATCH, 32'(m));
    apb_write(`TTC_OFS_INT_EN, 32'h2);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h19);
    apb_read(`TTC_OFS_INT_STAT, val);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h18);
    wait_irq(1'b1, m + 4, "match");
    apb_write(`TTC_OFS_CNT_CTRL, 32'h09);
    apb_read(`TTC_OFS_INT_STAT, val);
    check_equal("INT_STAT", val, 32'h2);
    // masked interrupt sets the status only
    apb_write(`TTC_OFS_INT_EN, 32'h0);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h19);
    apb_read(`TTC_OFS_INT_STAT, val);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h18);
    repeat (m + 4)
    begin
      @(negedge pclk30);
      check_equal("irq", irq, 0);
    end
    apb_write(`TTC_OFS_CNT_CTRL, 32'h09);
    apb_read(`TTC_OFS_INT_STAT, val);
    check_equal("INT_STAT", val, 32'h2);
  endtask

  // down from the interval with overflow on zero
  task automatic decrement_overflow();
    logic [31:0] val;
    logic [31:0] r;
    int          intv;
    int          n_reads;
    draw_random(r);
    intv = 16 + int'(r[4:0]);
    apb_write(`TTC_OFS_INTERVAL, 32'(intv));
    apb_write(`TTC_OFS_INT_EN, 32'h1);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h17);
    apb_read(`TTC_OFS_INT_STAT, val);
    apb_write(`TTC_OFS_CNT_CTRL, 32'h16);
    n_reads = 0;
    while (!irq && n_reads < (intv + 4) / 3 + 1)
    begin
      apb_read(`TTC_OFS_COUNT, val);
      if (val > 32'(intv))
        check_equal("COUNT", val, 32'(intv));
      n_reads++;
    end
    // three cycles per read, zero is reached only after intv ticks
    if (3 * n_reads < intv)
    begin
      $display("overflow interrupt came after %0d reads, before the count reached zero",
               n_reads);
      abort_run();
    end
    wait_irq(1'b1, 2, "decrement mode");
    apb_write(`TTC_OFS_CNT_CTRL, 32'h07);
    apb_read(`TTC_OFS_COUNT, val);
    if (val > 32'(intv))
      check_equal("COUNT", val, 32'(intv));
    apb_read(`TTC_OFS_INT_STAT, val);
    check_equal("INT_STAT", val, 32'h1);
    apb_write(`TTC_OFS_INT_EN, 32'h0);
  endtask

  // ------------------------------
  // sequence and watchdog
  // ------------------------------
  initial
  begin
    pclk30      = 1'b0;
    n_p_reset30 = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    rng_state   = 32'hed1bdd7f;
    repeat (RESET_CYCLES) @(negedge pclk30);
    n_p_reset30 = 1'b1;
    reset_and_readback();
    restart_while_disabled();
    prescaler_rates();
    interval_overflow();
    match_interrupt();
    decrement_overflow();
    $display("Simulation passed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    abort_run();
  end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/ttc_pkg.sv
rtl/ttc_cnt_if.sv
rtl/ttc_count_rst_lite.sv
rtl/ttc_regs.sv
rtl/ttc_prescaler.sv
rtl/ttc_counter.sv
rtl/ttc_timer_lite.sv
test/ttc_props.sv
test/tb_ttc_timer_lite.sv
